// File: design/id_remap_pkg.sv
// AXI read ID remapper, shared definitions.
// Holds the default sizes of the remap table and the fixed widths of the
// AR and R fields that pass through the remapper unchanged.

package id_remap_pkg;

  // Width of the sparse input IDs seen at the upstream port.
  localparam int unsigned DefSlvIdWidth = 8;

  // Number of table entries. This is also the number of distinct input IDs
  // that may be in flight at the same time.
  localparam int unsigned DefMaxUniqIds = 4;

  // Number of bursts that may be in flight for one input ID.
  localparam int unsigned DefMaxTxnsPerId = 3;

  // Width of the dense output IDs at the downstream port.
  // It has to cover the table index, and wider IDs are zero-extended.
  localparam int unsigned DefMstIdWidth = 3;

  // AR address.
  typedef logic [31:0] addr_t;

  // AR burst length, in beats minus one.
  typedef logic [7:0] len_t;

  // R data word.
  typedef logic [31:0] data_t;

  // R response code.
  typedef logic [1:0] resp_t;

  // Width of an index into a vector of num entries.
  // A single entry still gets a one-bit index so that no type collapses to
  // zero width.
  function automatic int unsigned idx_width(input int unsigned num);
    if (num > 32'd1) begin
      return $clog2(num);
    end
    return 32'd1;
  endfunction

endpackage

// File: design/remap_table_if.sv
// Remap table lookup and allocation bundle.
// Carries the push request from the AR stage to the table and the lookup
// results from the table back to the AR stage.

interface remap_table_if import id_remap_pkg::*; #(
  parameter int unsigned SlvIdWidth = DefSlvIdWidth,
  parameter int unsigned MaxUniqIds = DefMaxUniqIds
) ();

  localparam int unsigned IdxWidth = idx_width(MaxUniqIds);

  typedef logic [SlvIdWidth-1:0] slv_id_t;
  typedef logic [IdxWidth-1:0]   idx_t;

  // Allocation request. One push adds one burst to the entry at push_oup_id.
  logic    push;
  slv_id_t push_inp_id;
  idx_t    push_oup_id;

  // Lookup of the current AR input ID against the live entries.
  logic    exists;
  idx_t    exists_oup_id;
  logic    exists_full;

  // Lowest free entry, only meaningful while full is low.
  idx_t    free_oup_id;
  logic    full;

  // The AR stage makes the push decision.
  modport stage (
    output push, push_inp_id, push_oup_id,
    input  exists, exists_oup_id, exists_full, free_oup_id, full
  );

  // The table answers the lookup and applies the push.
  modport tbl (
    input  push, push_inp_id, push_oup_id,
    output exists, exists_oup_id, exists_full, free_oup_id, full
  );

endinterface

// File: design/lowest_set_finder.sv
// Lowest set bit finder.
// Returns the index of the lowest set bit of the input vector and flags a
// vector with no bit set.

module lowest_set_finder import id_remap_pkg::*; #(
  parameter int unsigned Width = DefMaxUniqIds,
  localparam int unsigned IdxWidth = idx_width(Width)
) (
  input  logic [Width-1:0]    in_i,
  output logic [IdxWidth-1:0] idx_o,
  output logic                empty_o
);

  // Walk upward from bit 0. The empty flag doubles as the "nothing found
  // yet" marker, so only the first set bit is taken and later ones are
  // ignored.
  always_comb begin
    idx_o   = '0;
    empty_o = 1'b1;
    for (int unsigned i = 0; i < Width; i++) begin
      if (in_i[i] && empty_o) begin
        idx_o   = IdxWidth'(i);
        empty_o = 1'b0;
      end
    end
  end

  // The index is zero whenever the vector is empty.
  // Users must look at empty_o before they trust idx_o.

endmodule

// File: design/id_remap_table.sv
// Read ID remap table.
// Holds one entry per output ID with the input ID that owns it and the
// number of bursts in flight. Answers lookups for the AR stage, counts up
// on an AR push and down on an R last beat, and restores input IDs on R.

module id_remap_table import id_remap_pkg::*; #(
  parameter int unsigned SlvIdWidth   = DefSlvIdWidth,
  parameter int unsigned MaxUniqIds   = DefMaxUniqIds,
  parameter int unsigned MaxTxnsPerId = DefMaxTxnsPerId,
  localparam int unsigned IdxWidth    = idx_width(MaxUniqIds),
  localparam type slv_id_t            = logic [SlvIdWidth-1:0],
  localparam type idx_t               = logic [IdxWidth-1:0]
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  remap_table_if.tbl        tbl_io,
  input  slv_id_t           lookup_id_i,
  input  logic              pop_i,
  input  idx_t              pop_oup_id_i,
  output slv_id_t           pop_inp_id_o
);

  // The counter must hold every value from zero up to the limit.
  localparam int unsigned CntWidth = $clog2(MaxTxnsPerId + 1);

  typedef logic [CntWidth-1:0]   cnt_t;
  typedef logic [MaxUniqIds-1:0] field_t;

  // Entry contents, indexed by output ID.
  slv_id_t inp_id_q [MaxUniqIds];
  cnt_t    cnt_q    [MaxUniqIds];
  cnt_t    cnt_d    [MaxUniqIds];

  field_t  free_mask;
  field_t  match_mask;
  logic    no_match;

  // An entry is free once its counter has dropped to zero.
  // Its stale input ID is then ignored by the lookup below.
  always_comb begin
    for (int unsigned i = 0; i < MaxUniqIds; i++) begin
      free_mask[i]  = (cnt_q[i] == '0);
      match_mask[i] = (cnt_q[i] != '0) && (inp_id_q[i] == lookup_id_i);
    end
  end

  // Lowest free output ID for a new input ID.
  lowest_set_finder #(
    .Width   (MaxUniqIds)
  ) u_free_finder (
    .in_i    (free_mask),
    .idx_o   (tbl_io.free_oup_id),
    .empty_o (tbl_io.full)
  );

  // Output ID already owned by the looked-up input ID, if any.
  lowest_set_finder #(
    .Width   (MaxUniqIds)
  ) u_match_finder (
    .in_i    (match_mask),
    .idx_o   (tbl_io.exists_oup_id),
    .empty_o (no_match)
  );

  assign tbl_io.exists      = !no_match;
  assign tbl_io.exists_full = (cnt_q[tbl_io.exists_oup_id] == cnt_t'(MaxTxnsPerId));

  // The R path reads the owner of the beat's output ID directly.
  assign pop_inp_id_o = inp_id_q[pop_oup_id_i];

  // Push and pop may hit the same entry in one cycle.
  // They are applied in turn so that the two updates cancel out.
  always_comb begin
    cnt_d = cnt_q;
    if (tbl_io.push) begin
      cnt_d[tbl_io.push_oup_id] = cnt_d[tbl_io.push_oup_id] + cnt_t'(1);
    end
    if (pop_i) begin
      cnt_d[pop_oup_id_i] = cnt_d[pop_oup_id_i] - cnt_t'(1);
    end
  end

  // In-flight counters.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int unsigned i = 0; i < MaxUniqIds; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Input ID of each entry. A push rewrites it with the same value when the
  // entry is already owned by that ID.
  always_ff @(posedge clk_i) begin
    if (tbl_io.push) begin
      inp_id_q[tbl_io.push_oup_id] <= tbl_io.push_inp_id;
    end
  end

  // The AR stage may only push into a free entry or into the one that its
  // input ID already owns.
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tbl_io.push |-> (cnt_q[tbl_io.push_oup_id] == '0) ||
                    (inp_id_q[tbl_io.push_oup_id] == tbl_io.push_inp_id))
    else $error("Push hits an entry owned by another input ID.");

  // The stage must respect the per-ID limit.
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tbl_io.push |-> (cnt_q[tbl_io.push_oup_id] < MaxTxnsPerId))
    else $error("Push exceeds the per-ID burst limit.");

  // Downstream must only close bursts that were issued.
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> (cnt_q[pop_oup_id_i] != '0))
    else $error("R last beat for an output ID with no burst in flight.");

  // An input ID owns at most one live entry.
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(match_mask))
    else $error("Input ID found in more than one entry.");

endmodule

// File: design/ar_remap_stage.sv
// AR remap stage.
// Decides whether an incoming AR may pass, picks its output ID from the
// remap table and pushes the new burst. Holds the output ID while the
// downstream port stalls so that the burst is pushed exactly once.

module ar_remap_stage import id_remap_pkg::*; #(
  parameter int unsigned SlvIdWidth = DefSlvIdWidth,
  parameter int unsigned MaxUniqIds = DefMaxUniqIds,
  parameter int unsigned MstIdWidth = DefMstIdWidth,
  localparam int unsigned IdxWidth  = idx_width(MaxUniqIds),
  localparam type slv_id_t          = logic [SlvIdWidth-1:0]
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  s_ar_valid_i,
  input  slv_id_t               s_ar_id_i,
  output logic                  s_ar_ready_o,
  output logic                  m_ar_valid_o,
  input  logic                  m_ar_ready_i,
  output logic [MstIdWidth-1:0] m_ar_id_o,
  remap_table_if.stage          tbl_io
);

  typedef logic [IdxWidth-1:0] idx_t;

  typedef enum logic {
    st_ready,
    st_hold
  } state_e;

  state_e state_q;
  state_e state_d;

  // Output ID of a burst that is waiting for downstream.
  idx_t   held_id_q;
  idx_t   held_id_d;

  // Output ID driven on the master side in this cycle.
  idx_t   oup_id;
  logic   allowed;

  // A known ID may add a burst while it is below its limit.
  // A new ID needs a free entry.
  assign allowed = tbl_io.exists ? !tbl_io.exists_full : !tbl_io.full;

  always_comb begin
    m_ar_valid_o       = 1'b0;
    s_ar_ready_o       = 1'b0;
    tbl_io.push        = 1'b0;
    tbl_io.push_inp_id = s_ar_id_i;
    oup_id             = tbl_io.exists ? tbl_io.exists_oup_id : tbl_io.free_oup_id;
    held_id_d          = held_id_q;
    state_d            = state_q;

    unique case (state_q)
      st_ready: begin
        // An existing ID reuses its output ID, which keeps the R order of
        // that ID intact. The entry is taken right away, even if downstream
        // is not ready yet.
        if (s_ar_valid_i && allowed) begin
          m_ar_valid_o = 1'b1;
          tbl_io.push  = 1'b1;
          s_ar_ready_o = m_ar_ready_i;
          if (!m_ar_ready_i) begin
            held_id_d = oup_id;
            state_d   = st_hold;
          end
        end
      end

      st_hold: begin
        // Replay the registered ID without a second push.
        oup_id       = held_id_q;
        m_ar_valid_o = 1'b1;
        s_ar_ready_o = m_ar_ready_i;
        if (m_ar_ready_i) begin
          state_d = st_ready;
        end
      end

      default: begin
        state_d = st_ready;
      end
    endcase
  end

  assign tbl_io.push_oup_id = oup_id;

  // Output IDs wider than the table index are zero-extended.
  assign m_ar_id_o = MstIdWidth'(oup_id);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= st_ready;
    end else begin
      state_q <= state_d;
    end
  end

  // Output ID that the hold state replays.
  always_ff @(posedge clk_i) begin
    held_id_q <= held_id_d;
  end

  // A stalled AR keeps its valid and its ID.
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_ar_valid_o && !m_ar_ready_i |=> m_ar_valid_o && $stable(m_ar_id_o))
    else $error("Stalled AR dropped valid or changed its ID.");

  // Upstream and downstream AR transfers happen in the same cycle, so an AR
  // that is replayed in the hold state is still offered by upstream.
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (s_ar_valid_i && s_ar_ready_o) == (m_ar_valid_o && m_ar_ready_i))
    else $error("Upstream and downstream AR transfers do not match.");

endmodule

// File: design/id_remap_top.sv
// AXI read ID remapper, top level.
// Maps wide, sparse input IDs on AR to narrow, dense output IDs and gives
// each R beat its original input ID back. Address, length and the R
// payload pass through unchanged.

module id_remap_top #(
  parameter int unsigned SlvIdWidth   = id_remap_pkg::DefSlvIdWidth,
  parameter int unsigned MaxUniqIds   = id_remap_pkg::DefMaxUniqIds,
  parameter int unsigned MaxTxnsPerId = id_remap_pkg::DefMaxTxnsPerId,
  parameter int unsigned MstIdWidth   = id_remap_pkg::DefMstIdWidth
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Upstream AR.
  input  logic                  s_ar_valid_i,
  output logic                  s_ar_ready_o,
  input  logic [SlvIdWidth-1:0] s_ar_id_i,
  input  id_remap_pkg::addr_t   s_ar_addr_i,
  input  id_remap_pkg::len_t    s_ar_len_i,
  // Downstream AR.
  output logic                  m_ar_valid_o,
  input  logic                  m_ar_ready_i,
  output logic [MstIdWidth-1:0] m_ar_id_o,
  output id_remap_pkg::addr_t   m_ar_addr_o,
  output id_remap_pkg::len_t    m_ar_len_o,
  // Downstream R.
  input  logic                  m_r_valid_i,
  output logic                  m_r_ready_o,
  input  logic [MstIdWidth-1:0] m_r_id_i,
  input  id_remap_pkg::data_t   m_r_data_i,
  input  id_remap_pkg::resp_t   m_r_resp_i,
  input  logic                  m_r_last_i,
  // Upstream R.
  output logic                  s_r_valid_o,
  input  logic                  s_r_ready_i,
  output logic [SlvIdWidth-1:0] s_r_id_o,
  output id_remap_pkg::data_t   s_r_data_o,
  output id_remap_pkg::resp_t   s_r_resp_o,
  output logic                  s_r_last_o
);

  localparam int unsigned IdxWidth = id_remap_pkg::idx_width(MaxUniqIds);

  remap_table_if #(
    .SlvIdWidth (SlvIdWidth),
    .MaxUniqIds (MaxUniqIds)
  ) tbl_if ();

  // AR side fields that need no remapping.
  assign m_ar_addr_o = s_ar_addr_i;
  assign m_ar_len_o  = s_ar_len_i;

  // R payload and handshake pass straight through.
  assign s_r_valid_o = m_r_valid_i;
  assign m_r_ready_o = s_r_ready_i;
  assign s_r_data_o  = m_r_data_i;
  assign s_r_resp_o  = m_r_resp_i;
  assign s_r_last_o  = m_r_last_i;

  ar_remap_stage #(
    .SlvIdWidth   (SlvIdWidth),
    .MaxUniqIds   (MaxUniqIds),
    .MstIdWidth   (MstIdWidth)
  ) u_ar_stage (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .s_ar_valid_i (s_ar_valid_i),
    .s_ar_id_i    (s_ar_id_i),
    .s_ar_ready_o (s_ar_ready_o),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_ready_i (m_ar_ready_i),
    .m_ar_id_o    (m_ar_id_o),
    .tbl_io       (tbl_if.stage)
  );

  // A burst is closed by its last beat once it completes the handshake.
  // Only the low bits of the R ID address the table.
  id_remap_table #(
    .SlvIdWidth   (SlvIdWidth),
    .MaxUniqIds   (MaxUniqIds),
    .MaxTxnsPerId (MaxTxnsPerId)
  ) u_table (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .tbl_io       (tbl_if.tbl),
    .lookup_id_i  (s_ar_id_i),
    .pop_i        (m_r_valid_i && s_r_ready_i && m_r_last_i),
    .pop_oup_id_i (m_r_id_i[IdxWidth-1:0]),
    .pop_inp_id_o (s_r_id_o)
  );

endmodule

// File: verification/tb_clock_gen.sv
// Testbench clock and reset generator.
// Toggles the clock with the given period and holds the active-low reset
// for a fixed number of rising edges.

module tb_clock_gen #(
  parameter int unsigned PeriodNs    = 8,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic arst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2.0) clk_o = ~clk_o;
  end

  // Release happens on a rising edge, like every other testbench drive.
  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

// File: verification/tb_id_remap_top.sv
// Testbench for the AXI read ID remapper.
// Applies a table of AR requests, blocked ARs and R beats, predicts every
// output ID and restored input ID with its own remap model and checks the
// DUT against it.

module tb_id_remap_top import id_remap_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned ClkPeriod   = 8;
  localparam int unsigned ResetCycles = 8;
  localparam int unsigned MaxStall    = 3;
  localparam int unsigned HoldCycles  = 3;
  localparam logic [1:0]  KindAr      = 2'd0;
  localparam logic [1:0]  KindR       = 2'd1;
  localparam logic [1:0]  KindBlk     = 2'd2;

  typedef logic [DefSlvIdWidth-1:0] slv_id_t;
  typedef logic [DefMstIdWidth-1:0] mst_id_t;

  // For AR steps id is the input ID and exp the output ID; R steps swap them.
  typedef struct packed {
    logic [1:0] kind;
    slv_id_t    id;
    logic       last;
    logic       stall;
    slv_id_t    exp;
  } step_t;

  logic clk_i, arst_n_i;
  logic s_ar_valid_i, s_ar_ready_o, m_ar_valid_o, m_ar_ready_i;
  slv_id_t s_ar_id_i, s_r_id_o;
  mst_id_t m_ar_id_o, m_r_id_i;
  addr_t s_ar_addr_i, m_ar_addr_o;
  len_t  s_ar_len_i, m_ar_len_o;
  logic m_r_valid_i, m_r_ready_o, m_r_last_i, s_r_valid_o, s_r_ready_i, s_r_last_o;
  data_t m_r_data_i, s_r_data_o;
  resp_t m_r_resp_i, s_r_resp_o;

  step_t   steps[$];
  bit      table_ready = 1'b0;
  int      value_errs  = 0;
  int      model_errs  = 0;
  integer  seed        = 32'h79027749;
  // Reference remap table, indexed by output ID.
  slv_id_t model_inp [DefMaxUniqIds];
  int      model_cnt [DefMaxUniqIds];

  tb_clock_gen #(.PeriodNs(ClkPeriod), .ResetCycles(ResetCycles)) u_clk_gen (
    .clk_o(clk_i), .arst_n_o(arst_n_i)
  );

  id_remap_top dut (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .s_ar_valid_i(s_ar_valid_i), .s_ar_ready_o(s_ar_ready_o), .s_ar_id_i(s_ar_id_i),
    .s_ar_addr_i(s_ar_addr_i), .s_ar_len_i(s_ar_len_i),
    .m_ar_valid_o(m_ar_valid_o), .m_ar_ready_i(m_ar_ready_i), .m_ar_id_o(m_ar_id_o),
    .m_ar_addr_o(m_ar_addr_o), .m_ar_len_o(m_ar_len_o),
    .m_r_valid_i(m_r_valid_i), .m_r_ready_o(m_r_ready_o), .m_r_id_i(m_r_id_i),
    .m_r_data_i(m_r_data_i), .m_r_resp_i(m_r_resp_i), .m_r_last_i(m_r_last_i),
    .s_r_valid_o(s_r_valid_o), .s_r_ready_i(s_r_ready_i), .s_r_id_o(s_r_id_o),
    .s_r_data_o(s_r_data_o), .s_r_resp_o(s_r_resp_o), .s_r_last_o(s_r_last_o)
  );

  task automatic check_oup_id(input string name, input mst_id_t got, input mst_id_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_inp_id(input string name, input slv_id_t got, input slv_id_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_len(input string name, input len_t got, input len_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errs++;
      $display("FAIL at %0t ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // A live entry with the same input ID wins and must be below the limit.
  // Otherwise the lowest entry with no burst in flight is taken.
  function automatic void model_lookup(input slv_id_t id, output int oid, output bit ok);
    int free_oid;
    oid      = -1;
    free_oid = -1;
    for (int i = DefMaxUniqIds - 1; i >= 0; i--) begin
      if (model_cnt[i] > 0 && model_inp[i] == id) oid = i;
      if (model_cnt[i] == 0) free_oid = i;
    end
    if (oid >= 0) begin
      ok = (model_cnt[oid] < DefMaxTxnsPerId);
    end else begin
      oid = free_oid;
      ok  = (free_oid >= 0);
    end
  endfunction

  // Raises an AR and keeps downstream ready low for the given stall count.
  // An AR that is already up from a blocked step keeps its address.
  // Valid, the output ID and the passed fields are checked until the transfer.
  task automatic send_ar(input slv_id_t id, input mst_id_t exp, input int stalls);
    int left;
    bit done;
    left = stalls;
    done = 1'b0;
    @(posedge clk_i);
    if (!s_ar_valid_i) begin
      s_ar_addr_i <= $random(seed);
    end
    s_ar_valid_i <= 1'b1;
    s_ar_id_i    <= id;
    s_ar_len_i   <= len_t'(id);
    m_ar_ready_i <= (left == 0);
    while (!done) begin
      @(negedge clk_i);
      check_flag("m_ar_valid_o", m_ar_valid_o, 1'b1);
      check_oup_id("m_ar_id_o", m_ar_id_o, exp);
      check_addr("m_ar_addr_o", m_ar_addr_o, s_ar_addr_i);
      check_len("m_ar_len_o", m_ar_len_o, len_t'(id));
      check_flag("s_ar_ready_o", s_ar_ready_o, m_ar_ready_i);
      done = m_ar_ready_i;
      @(posedge clk_i);
      left--;
      m_ar_ready_i <= !done && (left <= 0);
    end
    s_ar_valid_i <= 1'b0;
  endtask

  // The AR stays up with downstream ready, and nothing may pass. Ready is
  // dropped at the end so the burst is not taken before its own AR step.
  task automatic hold_blocked(input slv_id_t id, input int cycles);
    @(posedge clk_i);
    s_ar_valid_i <= 1'b1;
    s_ar_id_i    <= id;
    s_ar_len_i   <= len_t'(id);
    m_ar_ready_i <= 1'b1;
    repeat (cycles) begin
      @(negedge clk_i);
      check_flag("m_ar_valid_o", m_ar_valid_o, 1'b0);
      check_flag("s_ar_ready_o", s_ar_ready_o, 1'b0);
    end
    @(posedge clk_i);
    m_ar_ready_i <= 1'b0;
  endtask

  // One R beat, optionally held for a cycle by upstream back-pressure.
  task automatic send_r(input mst_id_t oid, input logic last, input logic stall,
                        input data_t data, input slv_id_t exp_inp);
    @(posedge clk_i);
    m_r_valid_i <= 1'b1;
    m_r_id_i    <= oid;
    m_r_data_i  <= data;
    m_r_resp_i  <= data[1:0];
    m_r_last_i  <= last;
    s_r_ready_i <= !stall;
    if (stall) begin
      @(negedge clk_i);
      check_flag("m_r_ready_o", m_r_ready_o, 1'b0);
      @(posedge clk_i);
      s_r_ready_i <= 1'b1;
    end
    @(negedge clk_i);
    check_flag("s_r_valid_o", s_r_valid_o, 1'b1);
    check_flag("m_r_ready_o", m_r_ready_o, 1'b1);
    check_inp_id("s_r_id_o", s_r_id_o, exp_inp);
    check_data("s_r_data_o", s_r_data_o, data);
    check_resp("s_r_resp_o", s_r_resp_o, data[1:0]);
    check_flag("s_r_last_o", s_r_last_o, last);
    @(posedge clk_i);
    m_r_valid_i <= 1'b0;
    m_r_last_i  <= 1'b0;
    s_r_ready_i <= 1'b0;
  endtask

  task automatic add_step(input logic [1:0] kind, input slv_id_t id, input logic last,
                          input logic stall, input slv_id_t exp);
    steps.push_back({kind, id, last, stall, exp});
  endtask

  task automatic load_steps();
    // Four new IDs fill the table in order, then one ID reaches its limit.
    add_step(KindAr,  8'h5A, 1'b0, 1'b0, 8'h00);
    add_step(KindAr,  8'hC3, 1'b0, 1'b0, 8'h01);
    add_step(KindAr,  8'h17, 1'b0, 1'b0, 8'h02);
    add_step(KindAr,  8'hE8, 1'b0, 1'b0, 8'h03);
    add_step(KindAr,  8'h5A, 1'b0, 1'b0, 8'h00);
    add_step(KindAr,  8'h5A, 1'b0, 1'b0, 8'h00);
    add_step(KindBlk, 8'h5A, 1'b0, 1'b0, 8'h00);
    add_step(KindR,   8'h00, 1'b1, 1'b0, 8'h5A);
    add_step(KindAr,  8'h5A, 1'b0, 1'b0, 8'h00);
    // A fifth ID waits through a non-last beat and takes the freed entry.
    add_step(KindBlk, 8'h99, 1'b0, 1'b0, 8'h00);
    add_step(KindR,   8'h02, 1'b0, 1'b0, 8'h17);
    add_step(KindBlk, 8'h99, 1'b0, 1'b0, 8'h00);
    add_step(KindR,   8'h02, 1'b1, 1'b0, 8'h17);
    add_step(KindAr,  8'h99, 1'b0, 1'b0, 8'h02);
    add_step(KindR,   8'h01, 1'b1, 1'b1, 8'hC3);
    add_step(KindAr,  8'h42, 1'b0, 1'b0, 8'h01);
    // Downstream stalls, after which the counts must still be exact.
    add_step(KindAr,  8'h99, 1'b0, 1'b1, 8'h02);
    add_step(KindAr,  8'h42, 1'b0, 1'b1, 8'h01);
    add_step(KindAr,  8'h42, 1'b0, 1'b1, 8'h01);
    add_step(KindBlk, 8'h42, 1'b0, 1'b0, 8'h00);
    add_step(KindR,   8'h01, 1'b1, 1'b0, 8'h42);
    add_step(KindAr,  8'h42, 1'b0, 1'b1, 8'h01);
    add_step(KindR,   8'h03, 1'b1, 1'b1, 8'hE8);
    add_step(KindAr,  8'h3C, 1'b0, 1'b1, 8'h03);
    add_step(KindR,   8'h00, 1'b1, 1'b0, 8'h5A);
  endtask

  initial begin
    step_t   st;
    int      oid;
    bit      ok;
    slv_id_t exp_inp;
    data_t   data;
    int      stalls;
    s_ar_valid_i = 1'b0;
    s_ar_id_i    = '0;
    s_ar_addr_i  = '0;
    s_ar_len_i   = '0;
    m_ar_ready_i = 1'b0;
    m_r_valid_i  = 1'b0;
    m_r_id_i     = '0;
    m_r_data_i   = '0;
    m_r_resp_i   = '0;
    m_r_last_i   = 1'b0;
    s_r_ready_i  = 1'b0;
    foreach (model_cnt[i]) begin
      model_cnt[i] = 0;
      model_inp[i] = '0;
    end
    load_steps();
    table_ready = 1'b1;
    @(posedge arst_n_i);
    foreach (steps[i]) begin
      st = steps[i];
      case (st.kind)
        KindAr: begin
          model_lookup(st.id, oid, ok);
          if (!ok || oid != int'(st.exp)) begin
            model_errs++;
            $display("Step %0d: the model does not pass input ID %h as output ID %0d.",
                     i, st.id, st.exp);
          end
          stalls = st.stall ? int'($unsigned($random(seed)) % (MaxStall + 1)) : 0;
          send_ar(st.id, mst_id_t'(oid), stalls);
          if (ok) begin
            model_inp[oid] = st.id;
            model_cnt[oid]++;
          end
        end
        KindBlk: begin
          model_lookup(st.id, oid, ok);
          if (ok) begin
            model_errs++;
            $display("Step %0d: the model admits input ID %h that should stall.", i, st.id);
          end
          hold_blocked(st.id, HoldCycles);
        end
        default: begin
          exp_inp = model_inp[st.id % DefMaxUniqIds];
          if (exp_inp !== st.exp) begin
            model_errs++;
            $display("Step %0d: the model restores input ID %h instead of %h.",
                     i, exp_inp, st.exp);
          end
          data = $random(seed);
          send_r(mst_id_t'(st.id), st.last, st.stall, data, exp_inp);
          if (st.last) model_cnt[st.id % DefMaxUniqIds]--;
        end
      endcase
    end
    repeat (2) @(posedge clk_i);
    $display("Errors: %0d value mismatches, %0d model mismatches", value_errs, model_errs);
    if (value_errs == 0 && model_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Each step takes at most the longest stall, the blocked hold and a few
  // handshake cycles.
  initial begin
    int limit;
    wait (table_ready);
    limit = (steps.size() * (MaxStall + HoldCycles + 4) + ResetCycles + 10) * ClkPeriod;
    #(limit);
    $display("Watchdog expired after %0d ns with test steps still running.", limit);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: id_remap_top.f
design/id_remap_pkg.sv
design/remap_table_if.sv
design/lowest_set_finder.sv
design/id_remap_table.sv
design/ar_remap_stage.sv
design/id_remap_top.sv
verification/tb_clock_gen.sv
verification/tb_id_remap_top.sv

// File: Bender.yml
package:
  name: id_remap

sources:
  - design/id_remap_pkg.sv
  - design/remap_table_if.sv
  - design/lowest_set_finder.sv
  - design/id_remap_table.sv
  - design/ar_remap_stage.sv
  - design/id_remap_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_id_remap_top.sv
